// File: include/rv_opcodes.svh
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// major opcodes of the supported subset
`define RV_OP_R      7'b0110011
`define RV_OP_I      7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

// funct3 for OP / OP-IMM
`define RV_F3_ADD    3'b000
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_XOR    3'b100
`define RV_F3_SRL    3'b101
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111

`define RV_F3_LW     3'b010
`define RV_F3_SW     3'b010
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100

`define RV_F7_BASE   7'b0000000
`define RV_F7_SUB    7'b0100000  // also the SRA/SRAI marker, not supported

`endif

// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] count_t;

    localparam inst_t nop_inst = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b,  // lui
        alu_link     // jal return address
    } alu_op_t;

    typedef enum logic [1:0] {
        brk_beq,
        brk_bne,
        brk_blt
    } brk_t;

    typedef enum logic [1:0] {
        strong_not_taken,
        weak_not_taken,
        weak_taken,
        strong_taken
    } bp_state_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    alu_src_imm;
        logic    lui;
        alu_op_t alu_op;
        brk_t    brk;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        ctrl_t    ctrl;
        logic     predicted;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        word_t    store_data;
        ctrl_t    ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    wdata;
        logic     reg_write;
    } mem_wb_t;

endpackage

// File: src/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_opcodes.svh"

module rv_decoder
    import rv_pkg::*;
(
    input  inst_t    inst,
    output ctrl_t    ctrl,
    output word_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    arith_op;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // shared by OP and OP-IMM, sub only exists in register form
    always_comb begin
        case (funct3)
            `RV_F3_ADD: arith_op = (opcode == `RV_OP_R && funct7 == `RV_F7_SUB) ? alu_sub : alu_add;
            `RV_F3_SLL: arith_op = alu_sll;
            `RV_F3_SLT: arith_op = alu_slt;
            `RV_F3_XOR: arith_op = alu_xor;
            `RV_F3_SRL: arith_op = alu_srl;
            `RV_F3_OR:  arith_op = alu_or;
            `RV_F3_AND: arith_op = alu_and;
            default:    arith_op = alu_add;  // sltu not in the subset
        endcase
    end

    always_comb begin
        ctrl = '0;  // unknown opcode ends up as a no-op
        imm  = '0;
        case (opcode)
            `RV_OP_R: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            `RV_OP_I: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = arith_op;
                imm              = imm_i;
            end
            `RV_OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.lui         = 1'b1;
                ctrl.alu_op      = alu_pass_b;
                imm              = imm_u;
            end
            `RV_OP_LOAD: begin
                if (funct3 == `RV_F3_LW) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    imm              = imm_i;
                end
            end
            `RV_OP_STORE: begin
                if (funct3 == `RV_F3_SW) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    imm              = imm_s;
                end
            end
            `RV_OP_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    `RV_F3_BEQ: begin
                        ctrl.branch = 1'b1;
                        ctrl.brk    = brk_beq;
                    end
                    `RV_F3_BNE: begin
                        ctrl.branch = 1'b1;
                        ctrl.brk    = brk_bne;
                    end
                    `RV_F3_BLT: begin
                        ctrl.branch = 1'b1;
                        ctrl.brk    = brk_blt;
                    end
                    default: ;
                endcase
            end
            `RV_OP_JAL: begin
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.alu_src_imm = 1'b1;  // no rs2 read
                ctrl.alu_op      = alu_link;
                imm              = imm_j;
            end
            default: ;
        endcase
    end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_addr_a,
    input  reg_idx_t rd_addr_b,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-before-read, x0 hardwired
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  brk_t    brk,
    output word_t   result,
    output logic    br_taken
);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sll:  result = a << b[4:0];
            alu_srl:  result = a >> b[4:0];
            alu_link: result = a + 32'd4;  // a carries the pc here
            default:  result = b;          // pass_b
        endcase
    end

    // compare runs beside the result path
    always_comb begin
        case (brk)
            brk_bne: br_taken = (a != b);
            brk_blt: br_taken = ($signed(a) < $signed(b));
            default: br_taken = (a == b);
        endcase
    end

endmodule

// File: src/rv_branch_predictor.sv
`timescale 1ns/1ps

module rv_branch_predictor
    import rv_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic resolve,
    input  logic actual_taken,
    output logic predict_taken
);

    bp_state_t state_q;
    bp_state_t state_d;

    // one saturating step toward the outcome
    always_comb begin
        state_d = state_q;
        if (resolve) begin
            case (state_q)
                strong_not_taken: state_d = actual_taken ? weak_not_taken : strong_not_taken;
                weak_not_taken:   state_d = actual_taken ? weak_taken : strong_not_taken;
                weak_taken:       state_d = actual_taken ? strong_taken : weak_not_taken;
                default:          state_d = actual_taken ? strong_taken : weak_taken;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= weak_not_taken;
        end else begin
            state_q <= state_d;
        end
    end

    // a branch in decode sees the update of the one resolving in execute
    assign predict_taken = (state_d == weak_taken) || (state_d == strong_taken);

endmodule

// File: src/rv_perf_counter.sv
`timescale 1ns/1ps

module rv_perf_counter
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   retire,
    input  logic   mispredict,
    output count_t retired_count,
    output count_t mispredict_count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_count    <= '0;
            mispredict_count <= '0;
        end else begin
            if (retire)     retired_count    <= retired_count + 32'd1;
            if (mispredict) mispredict_count <= mispredict_count + 32'd1;
        end
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output addr_t imem_addr,
    input  inst_t imem_data,
    output logic  dmem_valid,
    input  logic  dmem_ready,
    output addr_t dmem_addr,
    output logic  dmem_we,
    output word_t dmem_wdata,
    input  word_t dmem_rdata,
    output logic  bp_lookup,
    input  logic  bp_taken,
    output logic  bp_resolve,
    output logic  bp_actual,
    output logic  retire,
    output logic  mispredict
);

    addr_t    pc_q;
    addr_t    pc_d;
    if_id_t   if_id_q;
    id_ex_t   id_ex_q;
    id_ex_t   id_ex_d;
    ex_mem_t  ex_mem_q;
    ex_mem_t  ex_mem_d;
    mem_wb_t  mem_wb_q;
    mem_wb_t  mem_wb_d;

    ctrl_t    ctrl_d;
    word_t    imm_d;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    reg_idx_t rd_d;
    word_t    rf_a;
    word_t    rf_b;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     load_use;
    logic     redirect_d;

    word_t    fwd_a;
    word_t    fwd_b;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_res;
    logic     br_taken;
    addr_t    br_target;

    logic     mem_access;
    logic     mem_stall;

    // decode
    rv_decoder decoder_i (
        .inst (if_id_q.inst),
        .ctrl (ctrl_d),
        .imm  (imm_d),
        .rs1  (rs1_d),
        .rs2  (rs2_d),
        .rd   (rd_d)
    );

    rv_regfile regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rs1_d),
        .rd_addr_b (rs2_d),
        .wr_en     (mem_wb_q.valid & mem_wb_q.reg_write),
        .wr_addr   (mem_wb_q.rd),
        .wr_data   (mem_wb_q.wdata),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b)
    );

    assign uses_rs1 = ~(ctrl_d.lui | ctrl_d.jump);
    assign uses_rs2 = ~ctrl_d.alu_src_imm | ctrl_d.mem_write;  // stores read rs2 too

    assign load_use = if_id_q.valid && id_ex_q.valid && id_ex_q.ctrl.mem_read &&
                      id_ex_q.rd != '0 &&
                      ((uses_rs1 && id_ex_q.rd == rs1_d) || (uses_rs2 && id_ex_q.rd == rs2_d));

    assign bp_lookup  = if_id_q.valid & ctrl_d.branch;
    assign redirect_d = (if_id_q.valid & ctrl_d.jump) | (bp_lookup & bp_taken);

    assign id_ex_d = '{valid: if_id_q.valid, pc: if_id_q.pc, rs1: rs1_d, rs2: rs2_d,
                       rd: rd_d, op_a: rf_a, op_b: rf_b, imm: imm_d, ctrl: ctrl_d,
                       predicted: bp_lookup & bp_taken};

    // execute, mem result beats wb result
    function automatic word_t forward(reg_idx_t src, word_t reg_val);
        if (src != '0 && ex_mem_q.valid && ex_mem_q.ctrl.reg_write && ex_mem_q.rd == src)
            return ex_mem_q.result;
        if (src != '0 && mem_wb_q.valid && mem_wb_q.reg_write && mem_wb_q.rd == src)
            return mem_wb_q.wdata;
        return reg_val;
    endfunction

    always_comb begin
        fwd_a = forward(id_ex_q.rs1, id_ex_q.op_a);
        fwd_b = forward(id_ex_q.rs2, id_ex_q.op_b);
    end

    assign alu_a = id_ex_q.ctrl.jump ? id_ex_q.pc : fwd_a;
    assign alu_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : fwd_b;

    rv_alu alu_i (
        .op       (id_ex_q.ctrl.alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .brk      (id_ex_q.ctrl.brk),
        .result   (alu_res),
        .br_taken (br_taken)
    );

    assign br_target  = id_ex_q.pc + id_ex_q.imm;
    assign bp_resolve = id_ex_q.valid & id_ex_q.ctrl.branch & ~mem_stall;
    assign bp_actual  = br_taken;
    assign mispredict = bp_resolve & (br_taken != id_ex_q.predicted);

    assign ex_mem_d = '{valid: id_ex_q.valid, rd: id_ex_q.rd, result: alu_res,
                        store_data: fwd_b, ctrl: id_ex_q.ctrl};

    // memory stage owns the data port
    assign mem_access = ex_mem_q.valid & (ex_mem_q.ctrl.mem_read | ex_mem_q.ctrl.mem_write);
    assign mem_stall  = mem_access & ~dmem_ready;
    assign dmem_valid = mem_access;
    assign dmem_addr  = ex_mem_q.result;
    assign dmem_we    = ex_mem_q.ctrl.mem_write;
    assign dmem_wdata = ex_mem_q.store_data;
    assign retire     = ex_mem_q.valid & ~mem_stall;

    assign mem_wb_d = '{valid: ex_mem_q.valid, rd: ex_mem_q.rd,
                        wdata: ex_mem_q.ctrl.mem_read ? dmem_rdata : ex_mem_q.result,
                        reg_write: ex_mem_q.ctrl.reg_write};

    // next pc, execute redirect wins over decode
    always_comb begin
        pc_d = pc_q + 32'd4;
        if (mispredict) begin
            pc_d = br_taken ? br_target : id_ex_q.pc + 32'd4;
        end else if (load_use) begin
            pc_d = pc_q;
        end else if (redirect_d) begin
            pc_d = if_id_q.pc + imm_d;
        end
    end

    assign imem_addr = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q     <= '0;
            if_id_q  <= '{valid: 1'b0, pc: '0, inst: nop_inst};
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (!mem_stall) begin
            pc_q <= pc_d;
            if (mispredict || (redirect_d && !load_use)) begin
                if_id_q <= '{valid: 1'b0, pc: '0, inst: nop_inst};  // squash wrong-path fetch
            end else if (!load_use) begin
                if_id_q <= '{valid: 1'b1, pc: pc_q, inst: imem_data};
            end
            if (mispredict || load_use) begin
                id_ex_q <= '0;  // bubble
            end else begin
                id_ex_q <= id_ex_d;
            end
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

endmodule

// File: src/rv_subsys.sv
`timescale 1ns/1ps

module rv_subsys
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    output addr_t  imem_addr,
    input  inst_t  imem_data,
    output logic   dmem_valid,
    input  logic   dmem_ready,
    output addr_t  dmem_addr,
    output logic   dmem_we,
    output word_t  dmem_wdata,
    input  word_t  dmem_rdata,
    output count_t retired_count,
    output count_t mispredict_count
);

    logic bp_lookup;
    logic bp_taken;
    logic bp_resolve;
    logic bp_actual;
    logic predict_taken;
    logic retire;
    logic mispredict;

    rv_core core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_valid (dmem_valid),
        .dmem_ready (dmem_ready),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .bp_lookup  (bp_lookup),
        .bp_taken   (bp_taken),
        .bp_resolve (bp_resolve),
        .bp_actual  (bp_actual),
        .retire     (retire),
        .mispredict (mispredict)
    );

    rv_branch_predictor predictor_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .resolve       (bp_resolve),
        .actual_taken  (bp_actual),
        .predict_taken (predict_taken)
    );

    assign bp_taken = bp_lookup & predict_taken;  // only branches get a prediction

    rv_perf_counter perf_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .retire           (retire),
        .mispredict       (mispredict),
        .retired_count    (retired_count),
        .mispredict_count (mispredict_count)
    );

endmodule

// File: tb/rv_subsys_checker.sv
`timescale 1ns/1ps

module rv_subsys_checker
    import rv_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   dmem_valid,
    input logic   dmem_ready,
    input addr_t  dmem_addr,
    input logic   dmem_we,
    input word_t  dmem_wdata,
    input count_t retired_count,
    input count_t mispredict_count
);

    // a waiting request keeps address, direction and data
    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_addr) &&
                                      $stable(dmem_we) && $stable(dmem_wdata))
        else $error("data request changed while waiting for ready");

    assert property (@(posedge clk) !rst_n |-> !dmem_valid)
        else $error("dmem_valid high during reset");

    assert property (@(posedge clk) $rose(rst_n) |-> !dmem_valid)
        else $error("dmem_valid high right after reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        retired_count >= $past(retired_count))
        else $error("retired_count decreased");

    assert property (@(posedge clk) disable iff (!rst_n)
        mispredict_count >= $past(mispredict_count))
        else $error("mispredict_count decreased");

endmodule

bind rv_subsys rv_subsys_checker checker_i (.*);

// File: tb/tb_rv_subsys.sv
`timescale 1ns/1ps
`include "rv_opcodes.svh"

module tb_rv_subsys
    import rv_pkg::*;
();

    localparam int    NUM_TESTS = 4;
    localparam int    MAX_INSTS = 32;
    localparam int    MAX_STORES = 8;
    localparam addr_t HALT_ADDR = 32'hffc;

    logic   clk;
    logic   rst_n;
    addr_t  imem_addr;
    inst_t  imem_data;
    logic   dmem_valid;
    logic   dmem_ready;
    addr_t  dmem_addr;
    logic   dmem_we;
    word_t  dmem_wdata;
    word_t  dmem_rdata;
    count_t retired_count;
    count_t mispredict_count;

    // stimulus and expected values, one row per test
    inst_t       prog [NUM_TESTS][MAX_INSTS];
    int          plen [NUM_TESTS];
    addr_t       st_addr [NUM_TESTS][MAX_STORES];
    word_t       st_data [NUM_TESTS][MAX_STORES];
    int          n_st [NUM_TESTS];
    count_t      exp_retired [NUM_TESTS];
    logic [15:0] br_outcomes [NUM_TESTS];  // bit i is the i-th executed branch
    int          n_br [NUM_TESTS];
    logic        use_waits [NUM_TESTS];

    inst_t       imem [256];
    word_t       dmem [256];
    logic [31:0] rng_state;

    rv_subsys rv_subsys_i (.*);

    assign imem_data = imem[imem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic inst_t op_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, reg_idx_t'(rs2), reg_idx_t'(rs1), f3, reg_idx_t'(rd), `RV_OP_R};
    endfunction

    function automatic inst_t op_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
        word_t v;
        v = word_t'(imm);
        return {v[11:0], reg_idx_t'(rs1), f3, reg_idx_t'(rd), opc};
    endfunction

    function automatic inst_t op_sw(int rs2, int rs1, int imm);
        word_t v;
        v = word_t'(imm);
        return {v[11:5], reg_idx_t'(rs2), reg_idx_t'(rs1), `RV_F3_SW, v[4:0], `RV_OP_STORE};
    endfunction

    function automatic inst_t op_b(logic [2:0] f3, int rs1, int rs2, int imm);
        word_t v;
        v = word_t'(imm);
        return {v[12], v[10:5], reg_idx_t'(rs2), reg_idx_t'(rs1), f3, v[4:1], v[11],
                `RV_OP_BRANCH};
    endfunction

    function automatic inst_t op_jal(int rd, int imm);
        word_t v;
        v = word_t'(imm);
        return {v[20], v[10:1], v[11], v[19:12], reg_idx_t'(rd), `RV_OP_JAL};
    endfunction

    function automatic inst_t op_lui(int rd, int upper);
        word_t v;
        v = word_t'(upper);
        return {v[19:0], reg_idx_t'(rd), `RV_OP_LUI};
    endfunction

    // two-bit rule, starting weak not taken
    function automatic count_t two_bit_mispredicts(logic [15:0] outcomes, int n);
        int     state;
        count_t misses;
        state  = 1;
        misses = '0;
        for (int i = 0; i < n; i++) begin
            if ((state >= 2) != outcomes[i]) misses++;
            if (outcomes[i] && state < 3) state++;
            else if (!outcomes[i] && state > 0) state--;
        end
        return misses;
    endfunction

    task automatic emit(int t, inst_t i);
        prog[t][plen[t]] = i;
        plen[t]++;
    endtask

    task automatic expect_store(int t, addr_t a, word_t d);
        st_addr[t][n_st[t]] = a;
        st_data[t][n_st[t]] = d;
        n_st[t]++;
    endtask

    // store to 0xffc, then spin
    task automatic emit_halt(int t);
        emit(t, op_lui(31, 1));
        emit(t, op_sw(0, 31, -4));
        emit(t, op_jal(0, 0));
    endtask

    task automatic build_arith(int t);
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 1, 0, 5));
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 2, 0, -3));
        emit(t, op_r(`RV_F7_BASE, `RV_F3_ADD, 3, 1, 2));
        emit(t, op_r(`RV_F7_SUB, `RV_F3_ADD, 4, 1, 2));
        emit(t, op_r(`RV_F7_BASE, `RV_F3_SLT, 5, 2, 1));
        emit(t, op_i(`RV_OP_I, `RV_F3_XOR, 6, 1, 255));
        emit(t, op_r(`RV_F7_BASE, `RV_F3_SLL, 7, 1, 1));
        emit(t, op_i(`RV_OP_I, `RV_F3_SRL, 8, 2, 28));
        emit(t, op_lui(9, 32'h12345));
        emit(t, op_i(`RV_OP_I, `RV_F3_SLT, 10, 2, -2));
        for (int r = 3; r <= 10; r++) begin
            emit(t, op_sw(r, 0, (r - 3) * 4));
        end
        emit_halt(t);
        expect_store(t, 32'd0, 32'd2);
        expect_store(t, 32'd4, 32'd8);
        expect_store(t, 32'd8, 32'd1);          // -3 < 5
        expect_store(t, 32'd12, 32'd250);
        expect_store(t, 32'd16, 32'd160);
        expect_store(t, 32'd20, 32'h0000_000f);
        expect_store(t, 32'd24, 32'h1234_5000);
        expect_store(t, 32'd28, 32'd1);         // -3 < -2
        exp_retired[t] = 32'd20;
    endtask

    task automatic build_hazards(int t, logic waits);
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 1, 0, 7));
        emit(t, op_r(`RV_F7_BASE, `RV_F3_ADD, 2, 1, 1));
        emit(t, op_r(`RV_F7_SUB, `RV_F3_ADD, 3, 2, 1));
        emit(t, op_sw(3, 0, 0));
        emit(t, op_i(`RV_OP_LOAD, `RV_F3_LW, 4, 0, 0));
        emit(t, op_r(`RV_F7_BASE, `RV_F3_ADD, 5, 4, 2));  // load then use
        emit(t, op_sw(5, 0, 4));
        emit(t, op_i(`RV_OP_LOAD, `RV_F3_LW, 6, 0, 4));
        emit(t, op_sw(6, 0, 8));                          // store data from a load
        emit(t, op_r(`RV_F7_BASE, `RV_F3_OR, 7, 6, 1));
        emit(t, op_sw(7, 0, 12));
        emit_halt(t);
        expect_store(t, 32'd0, 32'd7);
        expect_store(t, 32'd4, 32'd21);
        expect_store(t, 32'd8, 32'd21);
        expect_store(t, 32'd12, 32'd23);
        exp_retired[t] = 32'd13;
        use_waits[t]   = waits;
    endtask

    task automatic build_control(int t);
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 1, 0, 3));     // loop count
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 2, 0, 0));
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 2, 2, 5));     // pc 8
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 1, 1, -1));
        emit(t, op_b(`RV_F3_BNE, 1, 0, -8));
        emit(t, op_sw(2, 0, 0));
        emit(t, op_b(`RV_F3_BEQ, 2, 2, 8));               // taken
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 2, 0, 99));    // skipped
        emit(t, op_b(`RV_F3_BLT, 2, 0, 8));               // not taken
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 3, 0, 1));
        emit(t, op_jal(4, 8));                            // pc 40
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 3, 0, 77));    // skipped
        emit(t, op_sw(3, 0, 4));
        emit(t, op_sw(4, 0, 8));
        emit(t, op_b(`RV_F3_BLT, 0, 2, 8));               // taken
        emit(t, op_sw(0, 0, 12));                         // skipped
        emit(t, op_i(`RV_OP_I, `RV_F3_ADD, 5, 0, -1));
        emit(t, op_b(`RV_F3_BEQ, 5, 0, 8));               // not taken
        emit(t, op_sw(5, 0, 12));
        emit_halt(t);
        expect_store(t, 32'd0, 32'd15);
        expect_store(t, 32'd4, 32'd1);
        expect_store(t, 32'd8, 32'd44);
        expect_store(t, 32'd12, 32'hffff_ffff);
        br_outcomes[t] = 16'b0010_1011;  // bne T T N, beq T, blt N, blt T, beq N
        n_br[t]        = 7;
        exp_retired[t] = 32'd24;
        use_waits[t]   = 1'b1;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            plen[t]        = 0;
            n_st[t]        = 0;
            br_outcomes[t] = '0;
            n_br[t]        = 0;
            use_waits[t]   = 1'b0;
            for (int i = 0; i < MAX_INSTS; i++) prog[t][i] = nop_inst;
        end
        build_arith(0);
        build_hazards(1, 1'b0);
        build_hazards(2, 1'b1);
        build_control(3);
    endtask

    task automatic stop_on_failure(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic compare_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_count(string what, count_t got, count_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic reset_dut(int t);
        @(negedge clk);
        rst_n      = 1'b0;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < MAX_INSTS) ? prog[t][i] : nop_inst;
            dmem[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    // data memory model, all decisions on the falling edge
    task automatic run_test(int t);
        int    st_idx;
        logic  halted;
        logic  drawn;
        int    waits;
        addr_t req_addr;
        logic  req_we;
        word_t req_wdata;
        st_idx = 0;
        halted = 1'b0;
        drawn  = 1'b0;
        waits  = 0;
        while (!halted) begin
            @(negedge clk);
            if (dmem_ready) begin
                // handshake finished at the last rising edge
                dmem_ready = 1'b0;
                drawn      = 1'b0;
                if (req_we && req_addr == HALT_ADDR) begin
                    halted = 1'b1;
                    compare_count("store count", count_t'(st_idx), count_t'(n_st[t]));
                    compare_count("retired_count", retired_count, exp_retired[t]);
                    compare_count("mispredict_count", mispredict_count,
                                  two_bit_mispredicts(br_outcomes[t], n_br[t]));
                end else if (req_we) begin
                    if (st_idx >= n_st[t]) begin
                        stop_on_failure($sformatf("test %0d made more stores than expected", t));
                    end
                    compare_addr("store address", req_addr, st_addr[t][st_idx]);
                    compare_word("store data", req_wdata, st_data[t][st_idx]);
                    dmem[req_addr[9:2]] = req_wdata;
                    st_idx++;
                end
            end
            if (!halted && dmem_valid) begin
                if (!drawn) begin
                    rng_state = xorshift(rng_state);
                    waits     = use_waits[t] ? int'(rng_state[1:0]) : 0;
                    drawn     = 1'b1;
                end
                if (waits == 0) begin
                    dmem_ready = 1'b1;
                    dmem_rdata = dmem[dmem_addr[9:2]];
                    req_addr   = dmem_addr;
                    req_we     = dmem_we;
                    req_wdata  = dmem_wdata;
                end else begin
                    waits--;
                end
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        rng_state  = 32'h7fb4;
        for (int i = 0; i < 256; i++) begin
            imem[i] = nop_inst;
        end
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            reset_dut(t);
            run_test(t);
        end
        $display("sim passed");
        $finish;
    end

    // budget covers all tests with worst-case wait states
    initial begin
        repeat (400 * NUM_TESTS) @(posedge clk);
        $display("timeout: the run hung before all tests reached the halt store");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: rv_subsys.f
+incdir+include
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_branch_predictor.sv
src/rv_perf_counter.sv
src/rv_core.sv
src/rv_subsys.sv
tb/rv_subsys_checker.sv
tb/tb_rv_subsys.sv

// File: Makefile
# Verilator build for the RV32I subsystem testbench
# any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_rv_subsys
FILELIST  ?= rv_subsys.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the simulation is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
